// File: common/stlb_pkg.sv
// Shared types and sizes for the second-level TLB.
// Sv39 only, no hypervisor stage, so there is one ASID and no VMID.
// 2 ways of 64 sets, indexed by VPN bits 5:0 (vaddr 17:12).
// Superpage entries still sit in the set given by their low VPN bits.

package stlb_pkg;

  localparam int unsigned VA_W      = 39;
  localparam int unsigned VPN_LVL_W = 9;
  localparam int unsigned VPN_W     = 27;
  localparam int unsigned PPN_W     = 44;
  localparam int unsigned ASID_W    = 16;
  localparam int unsigned NUM_SETS  = 64;
  localparam int unsigned IDX_W     = 6;
  localparam int unsigned NUM_WAYS  = 2;
  localparam int unsigned WAY_W     = $clog2(NUM_WAYS);
  localparam int unsigned LFSR_W    = 8;  // replacement LFSR

  // flat word for indexing, level fields for the superpage compare
  typedef union packed {
    logic [VPN_W-1:0] word;
    struct packed {
      logic [VPN_LVL_W-1:0] l2;  // gigapage level
      logic [VPN_LVL_W-1:0] l1;  // megapage level
      logic [VPN_LVL_W-1:0] l0;
    } lvl;
  } vpn_u;

  typedef struct packed {
    logic [PPN_W-1:0] ppn;
    logic             g;      // global, ASID ignored
    logic [7:0]       flags;  // d a u x w r v and spare
  } pte_t;

  typedef struct packed {
    logic [ASID_W-1:0] asid;
    vpn_u              vpn;
    logic              is_1g;
    logic              is_2m;
  } tag_t;

  // one RAM word
  typedef struct packed {
    tag_t tag;
    pte_t pte;
  } entry_t;

  typedef struct packed {
    logic              valid;
    vpn_u              vpn;
    logic [ASID_W-1:0] asid;
    logic              is_1g;
    logic              is_2m;
    pte_t              pte;
  } tlb_update_t;

  typedef struct packed {
    logic              valid;
    logic              is_itlb;  // 0 means the DTLB asked
    vpn_u              vpn;
    logic [ASID_W-1:0] asid;
  } lookup_t;

endpackage

// File: compile.f
common/stlb_pkg.sv
stlb_mem/stlb_way_ram.sv
stlb_mem/stlb_ram_arbiter.sv
source/stlb_lookup_req.sv
source/stlb_tag_match.sv
source/stlb_refill.sv
source/shared_tlb.sv
tests/tb_shared_tlb.sv

// File: run.sh
#!/bin/sh
# build and run the shared TLB testbench with Verilator, the log decides
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
{ verilator --binary --timing --assert -Wno-fatal -f compile.f \
    --top-module tb_shared_tlb -o tb_shared_tlb && ./obj_dir/tb_shared_tlb; } > sim.log 2>&1 \
  || echo "sim failed" >> sim.log
cat sim.log
grep -q "sim failed" sim.log && exit 1 || exit 0

// File: source/shared_tlb.sv
// Shared second-level TLB behind the ITLB and DTLB.
// A granted miss pulses in its own cycle, the update comes one cycle later.
// A lookup that collides with a refill is dropped and must be retried.
// flush_i clears all entries and overrides a refill in the same cycle.

`timescale 1ns/1ps

module shared_tlb (
  input  logic                              clk_i,
  input  logic                              rst_ni,
  input  logic                              flush_i,
  input  logic                              itlb_access_i,
  input  logic                              itlb_hit_i,
  input  logic [stlb_pkg::VA_W-1:0]         itlb_vaddr_i,
  input  logic [stlb_pkg::ASID_W-1:0]       itlb_asid_i,
  input  logic                              dtlb_access_i,
  input  logic                              dtlb_hit_i,
  input  logic [stlb_pkg::VA_W-1:0]         dtlb_vaddr_i,
  input  logic [stlb_pkg::ASID_W-1:0]       dtlb_asid_i,
  input  stlb_pkg::tlb_update_t             shared_tlb_update_i,
  output stlb_pkg::tlb_update_t             itlb_update_o,
  output stlb_pkg::tlb_update_t             dtlb_update_o,
  output logic                              itlb_miss_o,
  output logic                              dtlb_miss_o,
  output logic                              shared_tlb_hit_o
);

  logic                                     rd_req;
  logic [stlb_pkg::IDX_W-1:0]               rd_idx;
  logic                                     rd_gnt;
  stlb_pkg::lookup_t                        pending;
  logic                                     wr_req;
  logic [stlb_pkg::IDX_W-1:0]               wr_idx;
  logic [stlb_pkg::NUM_WAYS-1:0]            wr_way;
  stlb_pkg::entry_t                         wr_entry;
  logic [stlb_pkg::NUM_WAYS-1:0]            wr_valid_row;
  stlb_pkg::entry_t [stlb_pkg::NUM_WAYS-1:0] rd_entry;
  logic [stlb_pkg::NUM_WAYS-1:0]            rd_valid;

  stlb_lookup_req u_lookup_req (
    .clk_i, .rst_ni,
    .itlb_access_i, .itlb_hit_i, .itlb_vaddr_i, .itlb_asid_i,
    .dtlb_access_i, .dtlb_hit_i, .dtlb_vaddr_i, .dtlb_asid_i,
    .rd_gnt_i (rd_gnt), .rd_req_o (rd_req), .rd_idx_o (rd_idx),
    .itlb_miss_o, .dtlb_miss_o, .pending_o (pending)
  );

  stlb_refill u_refill (
    .clk_i, .rst_ni, .flush_i,
    .update_i (shared_tlb_update_i), .valid_row_i (wr_valid_row),
    .wr_req_o (wr_req), .wr_idx_o (wr_idx), .wr_way_o (wr_way), .wr_entry_o (wr_entry)
  );

  stlb_ram_arbiter u_ram_arbiter (
    .clk_i, .rst_ni, .flush_i,
    .rd_req_i (rd_req), .rd_idx_i (rd_idx), .rd_gnt_o (rd_gnt),
    .wr_req_i (wr_req), .wr_idx_i (wr_idx), .wr_way_i (wr_way), .wr_entry_i (wr_entry),
    .wr_valid_row_o (wr_valid_row), .rd_entry_o (rd_entry), .rd_valid_o (rd_valid)
  );

  stlb_tag_match u_tag_match (
    .pending_i (pending), .rd_entry_i (rd_entry), .rd_valid_i (rd_valid),
    .hit_o (shared_tlb_hit_o), .itlb_update_o, .dtlb_update_o
  );

endmodule

// File: source/stlb_lookup_req.sv
// Request stage: picks the missing first-level TLB and reads the set.
// DTLB wins, an ITLB miss only counts while the DTLB is idle.
// Miss pulse and pending lookup only on a granted read.

`timescale 1ns/1ps

module stlb_lookup_req (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  logic                        itlb_access_i,
  input  logic                        itlb_hit_i,
  input  logic [stlb_pkg::VA_W-1:0]   itlb_vaddr_i,
  input  logic [stlb_pkg::ASID_W-1:0] itlb_asid_i,
  input  logic                        dtlb_access_i,
  input  logic                        dtlb_hit_i,
  input  logic [stlb_pkg::VA_W-1:0]   dtlb_vaddr_i,
  input  logic [stlb_pkg::ASID_W-1:0] dtlb_asid_i,
  input  logic                        rd_gnt_i,
  output logic                        rd_req_o,
  output logic [stlb_pkg::IDX_W-1:0]  rd_idx_o,
  output logic                        itlb_miss_o,
  output logic                        dtlb_miss_o,
  output stlb_pkg::lookup_t           pending_o
);

  logic                        itlb_req;
  logic                        dtlb_req;
  logic                        fire;
  logic [stlb_pkg::VA_W-1:0]   vaddr_sel;
  logic [stlb_pkg::ASID_W-1:0] asid_sel;
  logic                        valid_q;
  logic                        is_itlb_q;
  stlb_pkg::vpn_u              vpn_q;
  logic [stlb_pkg::ASID_W-1:0] asid_q;

  assign itlb_req  = itlb_access_i & ~itlb_hit_i & ~dtlb_access_i;
  assign dtlb_req  = dtlb_access_i & ~dtlb_hit_i;
  assign vaddr_sel = dtlb_req ? dtlb_vaddr_i : itlb_vaddr_i;
  assign asid_sel  = dtlb_req ? dtlb_asid_i : itlb_asid_i;

  assign rd_req_o    = itlb_req | dtlb_req;
  assign rd_idx_o    = vaddr_sel[stlb_pkg::VA_W-stlb_pkg::VPN_W +: stlb_pkg::IDX_W];  // va 17:12
  assign fire        = rd_req_o & rd_gnt_i;
  assign itlb_miss_o = itlb_req & rd_gnt_i;
  assign dtlb_miss_o = dtlb_req & rd_gnt_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q   <= 1'b0;
      is_itlb_q <= 1'b0;
    end else begin
      valid_q <= fire;  // one lookup per cycle in flight
      if (fire) begin
        is_itlb_q <= ~dtlb_req;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (fire) begin
      vpn_q.word <= vaddr_sel[stlb_pkg::VA_W-1 -: stlb_pkg::VPN_W];
      asid_q     <= asid_sel;
    end
  end

  assign pending_o.valid   = valid_q;
  assign pending_o.is_itlb = is_itlb_q;
  assign pending_o.vpn     = vpn_q;
  assign pending_o.asid    = asid_q;

endmodule

// File: source/stlb_refill.sv
// Refill path: turns the update strobe into a RAM write.
// First invalid way of the set is filled, a full set takes the LFSR way.
// Writes are dropped while flush_i is high.
// LFSR taps are fixed for an 8-bit register.

`timescale 1ns/1ps

module stlb_refill (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  logic                          flush_i,
  input  stlb_pkg::tlb_update_t         update_i,
  input  logic [stlb_pkg::NUM_WAYS-1:0] valid_row_i,
  output logic                          wr_req_o,
  output logic [stlb_pkg::IDX_W-1:0]    wr_idx_o,
  output logic [stlb_pkg::NUM_WAYS-1:0] wr_way_o,
  output stlb_pkg::entry_t              wr_entry_o
);

  logic [stlb_pkg::LFSR_W-1:0]   lfsr_q;
  logic                          lfsr_fb;
  logic                          lfsr_step;
  logic                          all_valid;
  logic [stlb_pkg::WAY_W-1:0]    inv_way;
  logic [stlb_pkg::WAY_W-1:0]    rnd_way;
  logic [stlb_pkg::WAY_W-1:0]    repl_way;
  logic [stlb_pkg::NUM_WAYS-1:0] way_oh;

  assign all_valid = &valid_row_i;

  // lowest invalid way
  always_comb begin
    inv_way = '0;
    for (int w = stlb_pkg::NUM_WAYS - 1; w >= 0; w--) begin
      if (!valid_row_i[w]) begin
        inv_way = stlb_pkg::WAY_W'(w);
      end
    end
  end

  assign rnd_way  = lfsr_q[stlb_pkg::WAY_W-1:0];
  assign repl_way = all_valid ? rnd_way : inv_way;

  always_comb begin
    way_oh           = '0;
    way_oh[repl_way] = 1'b1;
  end

  //////////////////////////////////////////////////////////////////////
  // replacement LFSR, x^8 + x^6 + x^5 + x^4 + 1
  //////////////////////////////////////////////////////////////////////
  assign lfsr_fb   = lfsr_q[7] ^ lfsr_q[5] ^ lfsr_q[4] ^ lfsr_q[3];
  assign lfsr_step = wr_req_o & all_valid;  // only on eviction

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      lfsr_q <= '1;
    end else if (lfsr_step) begin
      lfsr_q <= {lfsr_q[stlb_pkg::LFSR_W-2:0], lfsr_fb};
    end
  end

  //////////////////////////////////////////////////////////////////////
  // write request
  //////////////////////////////////////////////////////////////////////
  assign wr_req_o = update_i.valid & ~flush_i;
  assign wr_idx_o = update_i.vpn.word[stlb_pkg::IDX_W-1:0];
  assign wr_way_o = way_oh;

  assign wr_entry_o.tag.asid  = update_i.asid;
  assign wr_entry_o.tag.vpn   = update_i.vpn;
  assign wr_entry_o.tag.is_1g = update_i.is_1g;
  assign wr_entry_o.tag.is_2m = update_i.is_2m;
  assign wr_entry_o.pte       = update_i.pte;

endmodule

// File: source/stlb_tag_match.sv
// Match stage, purely combinational on the registered RAM read.
// ASID is ignored for global PTEs. Superpages skip the lower VPN levels.
// The lowest hitting way wins when more than one way matches.

`timescale 1ns/1ps

module stlb_tag_match (
  input  stlb_pkg::lookup_t                          pending_i,
  input  stlb_pkg::entry_t [stlb_pkg::NUM_WAYS-1:0]  rd_entry_i,
  input  logic [stlb_pkg::NUM_WAYS-1:0]              rd_valid_i,
  output logic                                       hit_o,
  output stlb_pkg::tlb_update_t                      itlb_update_o,
  output stlb_pkg::tlb_update_t                      dtlb_update_o
);

  logic [stlb_pkg::NUM_WAYS-1:0] asid_ok;
  logic [stlb_pkg::NUM_WAYS-1:0] lvl2_ok;
  logic [stlb_pkg::NUM_WAYS-1:0] lvl1_ok;
  logic [stlb_pkg::NUM_WAYS-1:0] lvl0_ok;
  logic [stlb_pkg::NUM_WAYS-1:0] way_hit;
  stlb_pkg::entry_t              hit_entry;
  stlb_pkg::tlb_update_t         upd;

  //////////////////////////////////////////////////////////////////////
  // per-way compare
  //////////////////////////////////////////////////////////////////////
  for (genvar w = 0; w < stlb_pkg::NUM_WAYS; w++) begin : gen_way
    assign asid_ok[w] = (rd_entry_i[w].tag.asid == pending_i.asid) | rd_entry_i[w].pte.g;
    assign lvl2_ok[w] = rd_entry_i[w].tag.vpn.lvl.l2 == pending_i.vpn.lvl.l2;
    assign lvl1_ok[w] = rd_entry_i[w].tag.is_1g |
                        (rd_entry_i[w].tag.vpn.lvl.l1 == pending_i.vpn.lvl.l1);
    assign lvl0_ok[w] = rd_entry_i[w].tag.is_1g | rd_entry_i[w].tag.is_2m |
                        (rd_entry_i[w].tag.vpn.lvl.l0 == pending_i.vpn.lvl.l0);
    assign way_hit[w] = pending_i.valid & rd_valid_i[w] & asid_ok[w] &
                        lvl2_ok[w] & lvl1_ok[w] & lvl0_ok[w];
  end

  assign hit_o = |way_hit;

  // walk down so the lowest way is taken last
  always_comb begin
    hit_entry = rd_entry_i[0];
    for (int w = stlb_pkg::NUM_WAYS - 1; w >= 0; w--) begin
      if (way_hit[w]) begin
        hit_entry = rd_entry_i[w];
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // update word
  //////////////////////////////////////////////////////////////////////
  always_comb begin
    upd = '0;
    if (hit_o) begin
      upd.valid = 1'b1;
      upd.vpn   = pending_i.vpn;   // requested vpn, not the stored one
      upd.asid  = pending_i.asid;
      upd.is_1g = hit_entry.tag.is_1g;
      upd.is_2m = hit_entry.tag.is_2m;
      upd.pte   = hit_entry.pte;
    end
  end

  always_comb begin
    itlb_update_o = '0;
    dtlb_update_o = '0;
    if (pending_i.is_itlb) begin
      itlb_update_o = upd;
    end else begin
      dtlb_update_o = upd;
    end
  end

endmodule

// File: stlb_mem/stlb_ram_arbiter.sv
// Owns the way RAMs and the valid bits of the shared TLB.
// A write always wins the single RAM port, a colliding read is refused.
// Read data and the matching valid bits arrive one cycle after the grant.
// Flush clears all valid bits and also masks a read in the same cycle.

`timescale 1ns/1ps

module stlb_ram_arbiter (
  input  logic                                       clk_i,
  input  logic                                       rst_ni,
  input  logic                                       flush_i,
  input  logic                                       rd_req_i,
  input  logic [stlb_pkg::IDX_W-1:0]                 rd_idx_i,
  output logic                                       rd_gnt_o,
  input  logic                                       wr_req_i,
  input  logic [stlb_pkg::IDX_W-1:0]                 wr_idx_i,
  input  logic [stlb_pkg::NUM_WAYS-1:0]              wr_way_i,
  input  stlb_pkg::entry_t                           wr_entry_i,
  output logic [stlb_pkg::NUM_WAYS-1:0]              wr_valid_row_o,
  output stlb_pkg::entry_t [stlb_pkg::NUM_WAYS-1:0]  rd_entry_o,
  output logic [stlb_pkg::NUM_WAYS-1:0]              rd_valid_o
);

  logic [stlb_pkg::NUM_SETS-1:0][stlb_pkg::NUM_WAYS-1:0] valid_q;
  logic [stlb_pkg::NUM_WAYS-1:0]                         rd_valid_q;
  logic [stlb_pkg::IDX_W-1:0]                            ram_addr;
  logic [stlb_pkg::NUM_WAYS-1:0]                         ram_req;
  logic [stlb_pkg::NUM_WAYS-1:0]                         ram_we;

  assign rd_gnt_o = rd_req_i & ~wr_req_i;
  assign ram_addr = wr_req_i ? wr_idx_i : rd_idx_i;
  assign ram_we   = wr_req_i ? wr_way_i : '0;
  assign ram_req  = ram_we | {stlb_pkg::NUM_WAYS{rd_gnt_o}};

  assign wr_valid_row_o = valid_q[wr_idx_i];  // for the replacement choice

  //////////////////////////////////////////////////////////////////////
  // valid bits
  //////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= '0;
    end else if (flush_i) begin
      valid_q <= '0;
    end else if (wr_req_i) begin
      valid_q[wr_idx_i] <= valid_q[wr_idx_i] | wr_way_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rd_valid_q <= '0;
    end else begin
      rd_valid_q <= (rd_gnt_o & ~flush_i) ? valid_q[rd_idx_i] : '0;
    end
  end

  assign rd_valid_o = rd_valid_q;

  for (genvar w = 0; w < stlb_pkg::NUM_WAYS; w++) begin : gen_way
    stlb_way_ram u_way_ram (
      .clk_i   (clk_i),
      .req_i   (ram_req[w]),
      .we_i    (ram_we[w]),
      .addr_i  (ram_addr),
      .wdata_i (wr_entry_i),
      .rdata_o (rd_entry_o[w])
    );
  end

  // refill must select exactly one way
  a_wr_way_onehot: assert property (
    @(posedge clk_i) disable iff (!rst_ni) wr_req_i |-> $onehot(wr_way_i)
  ) else $error("refill write without a one-hot way mask");

endmodule

// File: stlb_mem/stlb_way_ram.sv
// One way of the shared TLB: tag and PTE in a single word.
// Single port, write or read per cycle, read data valid the next cycle.
// Contents are undefined until written.

`timescale 1ns/1ps

module stlb_way_ram (
  input  logic                       clk_i,
  input  logic                       req_i,
  input  logic                       we_i,
  input  logic [stlb_pkg::IDX_W-1:0] addr_i,
  input  stlb_pkg::entry_t           wdata_i,
  output stlb_pkg::entry_t           rdata_o
);

  stlb_pkg::entry_t mem [stlb_pkg::NUM_SETS];
  stlb_pkg::entry_t rdata_q;

  always_ff @(posedge clk_i) begin
    if (req_i) begin
      if (we_i) begin
        mem[addr_i] <= wdata_i;
      end else begin
        rdata_q <= mem[addr_i];  // holds across writes
      end
    end
  end

  assign rdata_o = rdata_q;

endmodule

// File: tests/tb_shared_tlb.sv
// Testbench for the shared second-level TLB.
// Inputs change 10 ns after the rising edge, outputs are sampled at the falling edge.
// The reference model keeps every refilled entry per set, so a set that
// was refilled three times is only checked loosely for the older entries.

`timescale 1ns/1ps

module tb_shared_tlb;

  localparam int RST_CYCLES = 16;
  localparam int N_ENT      = 8;
  // itlb 3*N, dtlb N + N/2 + 3, superpage 7, replacement 9, flush and collide N + 7
  localparam int STIM_CYCLES = RST_CYCLES + 5 * N_ENT + N_ENT / 2 + 26;
  localparam longint TIMEOUT_NS = longint'(STIM_CYCLES) * 100 * 2;

  typedef struct packed {
    logic                  valid;    // granted lookup this cycle
    logic                  is_itlb;
    logic                  loose;    // hit or miss both allowed
    logic                  imiss;
    logic                  dmiss;
    stlb_pkg::tlb_update_t upd;
  } expect_t;

  logic                          clk_i;
  logic                          rst_ni;
  logic                          flush_i;
  logic                          itlb_access_i;
  logic                          itlb_hit_i;
  logic [stlb_pkg::VA_W-1:0]     itlb_vaddr_i;
  logic [stlb_pkg::ASID_W-1:0]   itlb_asid_i;
  logic                          dtlb_access_i;
  logic                          dtlb_hit_i;
  logic [stlb_pkg::VA_W-1:0]     dtlb_vaddr_i;
  logic [stlb_pkg::ASID_W-1:0]   dtlb_asid_i;
  stlb_pkg::tlb_update_t         shared_tlb_update_i;
  stlb_pkg::tlb_update_t         itlb_update_o;
  stlb_pkg::tlb_update_t         dtlb_update_o;
  logic                          itlb_miss_o;
  logic                          dtlb_miss_o;
  logic                          shared_tlb_hit_o;

  logic [31:0]                   lfsr = 32'hb96fc8b3;
  string                         test_name = "reset";
  expect_t                       cur = '0;
  int                            loose_hits = 0;
  stlb_pkg::tlb_update_t         model_ent [stlb_pkg::NUM_SETS][4];
  int                            model_cnt [stlb_pkg::NUM_SETS];
  stlb_pkg::tlb_update_t         ent [N_ENT];

  shared_tlb dut0 (
    .clk_i, .rst_ni, .flush_i,
    .itlb_access_i, .itlb_hit_i, .itlb_vaddr_i, .itlb_asid_i,
    .dtlb_access_i, .dtlb_hit_i, .dtlb_vaddr_i, .dtlb_asid_i,
    .shared_tlb_update_i, .itlb_update_o, .dtlb_update_o,
    .itlb_miss_o, .dtlb_miss_o, .shared_tlb_hit_o
  );

  initial begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  //////////////////////////////////////////////////////////////////////
  // helpers
  //////////////////////////////////////////////////////////////////////
  // fibonacci lfsr x^32 + x^22 + x^2 + x + 1, one step per bit
  function automatic logic [63:0] rand_bits(input int n);
    logic [63:0] r;
    logic        fb;
    r = '0;
    for (int i = 0; i < n; i++) begin
      fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb};
      r    = {r[62:0], fb};
    end
    return r;
  endfunction

  function automatic stlb_pkg::tlb_update_t make_entry(input int set_idx, input logic g,
                                                        input logic is_1g, input logic is_2m);
    stlb_pkg::tlb_update_t u;
    u           = '0;
    u.valid     = 1'b1;
    u.vpn.word  = {21'(rand_bits(21)), 6'(set_idx)};  // low vpn bits pick the set
    u.asid      = 16'(rand_bits(16));
    u.is_1g     = is_1g;
    u.is_2m     = is_2m;
    u.pte.ppn   = 44'(rand_bits(44));
    u.pte.g     = g;
    u.pte.flags = 8'(rand_bits(8));
    return u;
  endfunction

  // expected update word, first stored entry that matches wins
  function automatic stlb_pkg::tlb_update_t predict(input stlb_pkg::vpn_u vpn,
                                                     input logic [stlb_pkg::ASID_W-1:0] asid);
    stlb_pkg::tlb_update_t e;
    stlb_pkg::tlb_update_t r;
    int                    idx;
    logic                  match;
    r   = '0;
    idx = int'(vpn.word[5:0]);
    for (int k = 0; k < model_cnt[idx]; k++) begin
      e     = model_ent[idx][k];
      match = (e.asid == asid || e.pte.g) && e.vpn.lvl.l2 == vpn.lvl.l2 &&
              (e.is_1g || e.vpn.lvl.l1 == vpn.lvl.l1) &&
              (e.is_1g || e.is_2m || e.vpn.lvl.l0 == vpn.lvl.l0);
      if (match && !r.valid) begin
        r       = e;
        r.vpn   = vpn;
        r.asid  = asid;
      end
    end
    return r;
  endfunction

  task automatic model_add(input stlb_pkg::tlb_update_t u);
    int idx;
    idx = int'(u.vpn.word[5:0]);
    model_ent[idx][model_cnt[idx]] = u;
    model_cnt[idx]++;
  endtask

  task automatic check_value(input string what, input logic [127:0] exp,
                             input logic [127:0] act);
    if (exp !== act) begin
      $display("ERR %s %s: expected %h actual %h", test_name, what, exp, act);
      $display("sim failed");
      $fatal(1, "mismatch");
    end
  endtask

  task automatic next_cycle();
    @(posedge clk_i);
    #10;
    itlb_access_i       = 1'b0;
    itlb_hit_i          = 1'b0;
    dtlb_access_i       = 1'b0;
    dtlb_hit_i          = 1'b0;
    flush_i             = 1'b0;
    shared_tlb_update_i = '0;
    cur                 = '0;
  endtask

  task automatic refill(input stlb_pkg::tlb_update_t u);
    shared_tlb_update_i = u;
    model_add(u);
    next_cycle();
  endtask

  task automatic lookup(input logic is_itlb, input stlb_pkg::vpn_u vpn,
                        input logic [stlb_pkg::ASID_W-1:0] asid, input logic loose);
    logic [stlb_pkg::VA_W-1:0] va;
    va = {vpn.word, 12'(rand_bits(12))};
    if (is_itlb) begin
      itlb_access_i = 1'b1;
      itlb_vaddr_i  = va;
      itlb_asid_i   = asid;
    end else begin
      dtlb_access_i = 1'b1;
      dtlb_vaddr_i  = va;
      dtlb_asid_i   = asid;
    end
    cur.valid   = 1'b1;
    cur.is_itlb = is_itlb;
    cur.loose   = loose;
    cur.imiss   = is_itlb;
    cur.dmiss   = ~is_itlb;
    cur.upd     = predict(vpn, asid);
    next_cycle();
  endtask

  // both tlbs miss together, dtlb must win
  task automatic dual_lookup(input stlb_pkg::tlb_update_t ie, input stlb_pkg::tlb_update_t de);
    itlb_access_i = 1'b1;
    itlb_vaddr_i  = {ie.vpn.word, 12'h0};
    itlb_asid_i   = ie.asid;
    dtlb_access_i = 1'b1;
    dtlb_vaddr_i  = {de.vpn.word, 12'h0};
    dtlb_asid_i   = de.asid;
    cur.valid     = 1'b1;
    cur.dmiss     = 1'b1;
    cur.upd       = predict(de.vpn, de.asid);
    next_cycle();
  endtask

  // first-level accesses that must not reach the shared TLB
  task automatic quiet_access(input logic i_acc, input logic i_hit, input logic d_acc,
                              input logic d_hit, input stlb_pkg::vpn_u vpn);
    itlb_access_i = i_acc;
    itlb_hit_i    = i_hit;
    itlb_vaddr_i  = {vpn.word, 12'h0};
    dtlb_access_i = d_acc;
    dtlb_hit_i    = d_hit;
    dtlb_vaddr_i  = {vpn.word, 12'h0};
    next_cycle();
  endtask

  // lookup loses to the refill, so nothing is expected
  task automatic collide(input stlb_pkg::tlb_update_t u);
    shared_tlb_update_i = u;
    model_add(u);
    itlb_access_i       = 1'b1;
    itlb_vaddr_i        = {u.vpn.word, 12'h0};
    itlb_asid_i         = u.asid;
    next_cycle();
  endtask

  //////////////////////////////////////////////////////////////////////
  // compare process
  //////////////////////////////////////////////////////////////////////
  initial begin : compare
    expect_t               prev;
    stlb_pkg::tlb_update_t exp_upd;
    stlb_pkg::tlb_update_t exp_i;
    stlb_pkg::tlb_update_t exp_d;
    prev = '0;
    wait (rst_ni === 1'b1);
    forever begin
      @(negedge clk_i);
      check_value("itlb_miss_o", 128'(cur.imiss), 128'(itlb_miss_o));
      check_value("dtlb_miss_o", 128'(cur.dmiss), 128'(dtlb_miss_o));
      exp_upd = prev.valid ? prev.upd : '0;
      if (prev.valid && prev.loose) begin
        if (shared_tlb_hit_o) begin
          loose_hits++;
        end else begin
          exp_upd = '0;
        end
      end
      exp_i = prev.is_itlb ? exp_upd : '0;
      exp_d = prev.is_itlb ? '0 : exp_upd;
      check_value("shared_tlb_hit_o", 128'(exp_upd.valid), 128'(shared_tlb_hit_o));
      check_value("itlb_update_o", 128'(exp_i), 128'(itlb_update_o));
      check_value("dtlb_update_o", 128'(exp_d), 128'(dtlb_update_o));
      prev = cur;
    end
  end

  initial begin : watchdog
    #(TIMEOUT_NS);
    $display("watchdog expired after %0d ns before the tests finished", TIMEOUT_NS);
    $display("sim failed");
    $fatal(1, "timeout");
  end

  //////////////////////////////////////////////////////////////////////
  // stimulus
  //////////////////////////////////////////////////////////////////////
  initial begin : stimulus
    stlb_pkg::tlb_update_t sp2m;
    stlb_pkg::tlb_update_t sp1g;
    stlb_pkg::tlb_update_t extra;
    stlb_pkg::tlb_update_t r [3];
    stlb_pkg::vpn_u        v;
    for (int s = 0; s < stlb_pkg::NUM_SETS; s++) begin
      model_cnt[s] = 0;
    end
    rst_ni              = 1'b0;
    flush_i             = 1'b0;
    itlb_access_i       = 1'b0;
    itlb_hit_i          = 1'b0;
    itlb_vaddr_i        = '0;
    itlb_asid_i         = '0;
    dtlb_access_i       = 1'b0;
    dtlb_hit_i          = 1'b0;
    dtlb_vaddr_i        = '0;
    dtlb_asid_i         = '0;
    shared_tlb_update_i = '0;
    repeat (RST_CYCLES) @(posedge clk_i);
    #10;
    rst_ni = 1'b1;

    test_name = "itlb_path";
    for (int i = 0; i < N_ENT; i++) begin
      ent[i] = make_entry(i, i[0], 1'b0, 1'b0);  // odd entries are global
      refill(ent[i]);
    end
    for (int i = 0; i < N_ENT; i++) begin
      lookup(1'b1, ent[i].vpn, ent[i].asid, 1'b0);
    end
    for (int i = 0; i < N_ENT; i++) begin
      lookup(1'b1, ent[i].vpn, ent[i].asid ^ 16'h1, 1'b0);  // wrong asid
    end

    test_name = "dtlb_path";
    for (int i = 0; i < N_ENT; i++) begin
      lookup(1'b0, ent[i].vpn, ent[i].asid, 1'b0);
    end
    test_name = "priority";
    for (int i = 0; i < N_ENT / 2; i++) begin
      dual_lookup(ent[2 * i], ent[2 * i + 1]);
    end
    test_name = "first_level_hit";
    quiet_access(1'b1, 1'b1, 1'b0, 1'b0, ent[0].vpn);  // itlb hit
    quiet_access(1'b0, 1'b0, 1'b1, 1'b1, ent[1].vpn);  // dtlb hit
    quiet_access(1'b1, 1'b0, 1'b1, 1'b1, ent[2].vpn);  // busy dtlb holds the itlb miss

    test_name = "superpage";
    sp2m = make_entry(16, 1'b0, 1'b0, 1'b1);
    sp1g = make_entry(17, 1'b0, 1'b1, 1'b0);
    refill(sp2m);
    refill(sp1g);
    v = sp2m.vpn;
    v.lvl.l0[8:6] = v.lvl.l0[8:6] ^ 3'b101;  // low level ignored
    lookup(1'b1, v, sp2m.asid, 1'b0);
    v.lvl.l1 = v.lvl.l1 ^ 9'h001;             // compared level differs
    lookup(1'b1, v, sp2m.asid, 1'b0);
    v = sp1g.vpn;
    v.lvl.l1 = 9'(rand_bits(9));
    v.lvl.l0[8:6] = 3'(rand_bits(3));
    lookup(1'b0, v, sp1g.asid, 1'b0);
    v.lvl.l2 = v.lvl.l2 ^ 9'h100;
    lookup(1'b0, v, sp1g.asid, 1'b0);
    lookup(1'b0, sp2m.vpn, sp2m.asid, 1'b0);

    test_name = "replacement";
    for (int i = 0; i < 3; i++) begin
      r[i] = make_entry(32, 1'b0, 1'b0, 1'b0);
    end
    refill(r[0]);
    refill(r[1]);
    lookup(1'b1, r[0].vpn, r[0].asid, 1'b0);
    lookup(1'b1, r[1].vpn, r[1].asid, 1'b0);
    refill(r[2]);
    loose_hits = 0;
    lookup(1'b1, r[0].vpn, r[0].asid, 1'b1);
    lookup(1'b1, r[1].vpn, r[1].asid, 1'b1);
    lookup(1'b1, r[2].vpn, r[2].asid, 1'b0);  // newest always present
    next_cycle();
    check_value("older entries left", 128'd1, 128'(loose_hits));

    test_name = "flush";
    extra   = make_entry(40, 1'b1, 1'b0, 1'b0);
    flush_i = 1'b1;
    shared_tlb_update_i = extra;  // lost to the flush
    for (int s = 0; s < stlb_pkg::NUM_SETS; s++) begin
      model_cnt[s] = 0;
    end
    next_cycle();
    for (int i = 0; i < N_ENT; i++) begin
      lookup(1'b1, ent[i].vpn, ent[i].asid, 1'b0);
    end
    lookup(1'b0, sp2m.vpn, sp2m.asid, 1'b0);
    lookup(1'b0, extra.vpn, extra.asid, 1'b0);

    test_name = "arbitration";
    extra = make_entry(48, 1'b0, 1'b0, 1'b0);
    collide(extra);
    lookup(1'b1, extra.vpn, extra.asid, 1'b0);  // retry sees the refill
    next_cycle();
    next_cycle();

    $display("sim passed");
    $finish;
  end

endmodule
